//--- design/arb_pkg.sv
// Arbitration state shared by the channel mux and its checkers
package arb_pkg;

    // Round-robin flag of the two-channel mux
    // Holds the channel that wins when both channels request
    typedef enum logic
    {
        SEL_CH0 = 1'b0,
        SEL_CH1 = 1'b1
    } chan_sel_e;

endpackage : arb_pkg

//--- design/chan_mux2.sv
`timescale 1ns/10ps

module chan_mux2
    import tcdm_req_pkg::*, arb_pkg::*;
#(
    parameter int unsigned ADDR_WIDTH = 32,
    parameter int unsigned DATA_WIDTH = 32,
    parameter int unsigned ID_WIDTH   = 6
)
(
    input  logic                      clk,
    input  logic                      rst_n_i,

    // Channel 0 winner
    input  logic                      req_ch0_i,
    input  logic    [ADDR_WIDTH-1:0]  add_ch0_i,
    input  mem_op_e                   wen_ch0_i,
    input  logic    [DATA_WIDTH-1:0]  wdata_ch0_i,
    input  logic [DATA_WIDTH/8-1:0]   be_ch0_i,
    input  logic    [ID_WIDTH-1:0]    id_ch0_i,
    output logic                      stall_ch0_o,

    // Channel 1 winner
    input  logic                      req_ch1_i,
    input  logic    [ADDR_WIDTH-1:0]  add_ch1_i,
    input  mem_op_e                   wen_ch1_i,
    input  logic    [DATA_WIDTH-1:0]  wdata_ch1_i,
    input  logic [DATA_WIDTH/8-1:0]   be_ch1_i,
    input  logic    [ID_WIDTH-1:0]    id_ch1_i,
    output logic                      stall_ch1_o,

    // Memory port
    output logic                      req_o,
    output logic    [ADDR_WIDTH-1:0]  add_o,
    output mem_op_e                   wen_o,
    output logic    [DATA_WIDTH-1:0]  wdata_o,
    output logic [DATA_WIDTH/8-1:0]   be_o,
    output logic    [ID_WIDTH-1:0]    id_o,
    input  logic                      stall_i
);

    chan_sel_e           sel_q;
    logic                pick_ch1;

    // Flag flips on every accepted memory request
    always_ff @(posedge clk)
    begin
        if (!rst_n_i)
            sel_q <= SEL_CH0;
        else if (req_o && !stall_i)
            sel_q <= (sel_q == SEL_CH0) ? SEL_CH1 : SEL_CH0;
    end

    // Flag decides only on a conflict
    assign pick_ch1 = (req_ch0_i && req_ch1_i) ? (sel_q == SEL_CH1) : req_ch1_i;

    assign req_o   = req_ch0_i | req_ch1_i;
    assign add_o   = pick_ch1 ? add_ch1_i   : add_ch0_i;
    assign wen_o   = pick_ch1 ? wen_ch1_i   : wen_ch0_i;
    assign wdata_o = pick_ch1 ? wdata_ch1_i : wdata_ch0_i;
    assign be_o    = pick_ch1 ? be_ch1_i    : be_ch0_i;
    assign id_o    = pick_ch1 ? id_ch1_i    : id_ch0_i;

    // Back-pressure to the loser, or to the winner when memory stalls
    assign stall_ch0_o = req_ch0_i & (pick_ch1 | stall_i);
    assign stall_ch1_o = req_ch1_i & (~pick_ch1 | stall_i);

endmodule : chan_mux2

//--- design/request_block_2ch.sv
`timescale 1ns/10ps

module request_block_2ch
    import tcdm_req_pkg::*;
#(
    parameter int unsigned  ADDR_WIDTH = DEF_ADDR_WIDTH,
    parameter int unsigned  DATA_WIDTH = DEF_DATA_WIDTH,
    parameter int unsigned  N_CH0      = 4,
    parameter int unsigned  N_CH1      = 2,
    localparam int unsigned ID_WIDTH   = N_CH0 + N_CH1,
    localparam int unsigned BE_WIDTH   = DATA_WIDTH / 8
)
(
    input  logic                                  clk,
    input  logic                                  rst_n_i,

    // Channel 0, cores
    input  logic    [N_CH0-1:0]                   req_ch0_i,
    input  logic    [N_CH0-1:0][ADDR_WIDTH-1:0]   add_ch0_i,
    input  mem_op_e [N_CH0-1:0]                   wen_ch0_i,
    input  logic    [N_CH0-1:0][DATA_WIDTH-1:0]   wdata_ch0_i,
    input  logic    [N_CH0-1:0][BE_WIDTH-1:0]     be_ch0_i,
    input  logic    [N_CH0-1:0][ID_WIDTH-1:0]     id_ch0_i,
    output logic    [N_CH0-1:0]                   stall_ch0_o,

    // Channel 1, DMA ports
    input  logic    [N_CH1-1:0]                   req_ch1_i,
    input  logic    [N_CH1-1:0][ADDR_WIDTH-1:0]   add_ch1_i,
    input  mem_op_e [N_CH1-1:0]                   wen_ch1_i,
    input  logic    [N_CH1-1:0][DATA_WIDTH-1:0]   wdata_ch1_i,
    input  logic    [N_CH1-1:0][BE_WIDTH-1:0]     be_ch1_i,
    input  logic    [N_CH1-1:0][ID_WIDTH-1:0]     id_ch1_i,
    output logic    [N_CH1-1:0]                   stall_ch1_o,

    // Memory port
    output logic                                  req_o,
    output logic    [ADDR_WIDTH-1:0]              add_o,
    output mem_op_e                               wen_o,
    output logic    [DATA_WIDTH-1:0]              wdata_o,
    output logic    [BE_WIDTH-1:0]                be_o,
    output logic    [ID_WIDTH-1:0]                id_o,
    input  logic                                  stall_i,

    // Response valid, steered back by one-hot ID
    input  logic                                  r_valid_i,
    input  logic    [ID_WIDTH-1:0]                r_id_i,
    output logic    [N_CH0-1:0]                   r_valid_ch0_o,
    output logic    [N_CH1-1:0]                   r_valid_ch1_o
);

    // Tree winners into the channel mux
    logic                   req_ch0;
    logic [ADDR_WIDTH-1:0]  add_ch0;
    mem_op_e                wen_ch0;
    logic [DATA_WIDTH-1:0]  wdata_ch0;
    logic [BE_WIDTH-1:0]    be_ch0;
    logic [ID_WIDTH-1:0]    id_ch0;
    logic                   stall_ch0;

    logic                   req_ch1;
    logic [ADDR_WIDTH-1:0]  add_ch1;
    mem_op_e                wen_ch1;
    logic [DATA_WIDTH-1:0]  wdata_ch1;
    logic [BE_WIDTH-1:0]    be_ch1;
    logic [ID_WIDTH-1:0]    id_ch1;
    logic                   stall_ch1;

    ////////////////////////////////////////////////////////////////////////////
    // Channel trees
    ////////////////////////////////////////////////////////////////////////////

    rr_arb_tree
    #(
        .N_MASTER   ( N_CH0       ),
        .ADDR_WIDTH ( ADDR_WIDTH  ),
        .DATA_WIDTH ( DATA_WIDTH  ),
        .ID_WIDTH   ( ID_WIDTH    )
    )
    u_tree_ch0
    (
        .clk        ( clk         ),
        .rst_n_i    ( rst_n_i     ),
        .req_i      ( req_ch0_i   ),
        .add_i      ( add_ch0_i   ),
        .wen_i      ( wen_ch0_i   ),
        .wdata_i    ( wdata_ch0_i ),
        .be_i       ( be_ch0_i    ),
        .id_i       ( id_ch0_i    ),
        .stall_o    ( stall_ch0_o ),
        .req_o      ( req_ch0     ),
        .add_o      ( add_ch0     ),
        .wen_o      ( wen_ch0     ),
        .wdata_o    ( wdata_ch0   ),
        .be_o       ( be_ch0      ),
        .id_o       ( id_ch0      ),
        .stall_i    ( stall_ch0   )
    );

    rr_arb_tree
    #(
        .N_MASTER   ( N_CH1       ),
        .ADDR_WIDTH ( ADDR_WIDTH  ),
        .DATA_WIDTH ( DATA_WIDTH  ),
        .ID_WIDTH   ( ID_WIDTH    )
    )
    u_tree_ch1
    (
        .clk        ( clk         ),
        .rst_n_i    ( rst_n_i     ),
        .req_i      ( req_ch1_i   ),
        .add_i      ( add_ch1_i   ),
        .wen_i      ( wen_ch1_i   ),
        .wdata_i    ( wdata_ch1_i ),
        .be_i       ( be_ch1_i    ),
        .id_i       ( id_ch1_i    ),
        .stall_o    ( stall_ch1_o ),
        .req_o      ( req_ch1     ),
        .add_o      ( add_ch1     ),
        .wen_o      ( wen_ch1     ),
        .wdata_o    ( wdata_ch1   ),
        .be_o       ( be_ch1      ),
        .id_o       ( id_ch1      ),
        .stall_i    ( stall_ch1   )
    );

    ////////////////////////////////////////////////////////////////////////////
    // Channel mux onto the memory port
    ////////////////////////////////////////////////////////////////////////////

    chan_mux2
    #(
        .ADDR_WIDTH  ( ADDR_WIDTH ),
        .DATA_WIDTH  ( DATA_WIDTH ),
        .ID_WIDTH    ( ID_WIDTH   )
    )
    u_chan_mux
    (
        .clk         ( clk        ),
        .rst_n_i     ( rst_n_i    ),
        .req_ch0_i   ( req_ch0    ),
        .add_ch0_i   ( add_ch0    ),
        .wen_ch0_i   ( wen_ch0    ),
        .wdata_ch0_i ( wdata_ch0  ),
        .be_ch0_i    ( be_ch0     ),
        .id_ch0_i    ( id_ch0     ),
        .stall_ch0_o ( stall_ch0  ),
        .req_ch1_i   ( req_ch1    ),
        .add_ch1_i   ( add_ch1    ),
        .wen_ch1_i   ( wen_ch1    ),
        .wdata_ch1_i ( wdata_ch1  ),
        .be_ch1_i    ( be_ch1     ),
        .id_ch1_i    ( id_ch1     ),
        .stall_ch1_o ( stall_ch1  ),
        .req_o       ( req_o      ),
        .add_o       ( add_o      ),
        .wen_o       ( wen_o      ),
        .wdata_o     ( wdata_o    ),
        .be_o        ( be_o       ),
        .id_o        ( id_o       ),
        .stall_i     ( stall_i    )
    );

    ////////////////////////////////////////////////////////////////////////////
    // Response valid routing
    ////////////////////////////////////////////////////////////////////////////

    // Low ID bits map to channel 0, the upper ones to channel 1
    assign r_valid_ch0_o = {N_CH0{r_valid_i}} & r_id_i[N_CH0-1:0];
    assign r_valid_ch1_o = {N_CH1{r_valid_i}} & r_id_i[ID_WIDTH-1:N_CH0];

endmodule : request_block_2ch

//--- design/rr_arb_tree.sv
`timescale 1ns/10ps

module rr_arb_tree
    import tcdm_req_pkg::*;
#(
    parameter int unsigned N_MASTER   = 4,
    parameter int unsigned ADDR_WIDTH = 32,
    parameter int unsigned DATA_WIDTH = 32,
    parameter int unsigned ID_WIDTH   = 6
)
(
    input  logic                                 clk,
    input  logic                                 rst_n_i,

    // Master side
    input  logic    [N_MASTER-1:0]                   req_i,
    input  logic    [N_MASTER-1:0][ADDR_WIDTH-1:0]   add_i,
    input  mem_op_e [N_MASTER-1:0]                   wen_i,
    input  logic    [N_MASTER-1:0][DATA_WIDTH-1:0]   wdata_i,
    input  logic    [N_MASTER-1:0][DATA_WIDTH/8-1:0] be_i,
    input  logic    [N_MASTER-1:0][ID_WIDTH-1:0]     id_i,
    output logic    [N_MASTER-1:0]                   stall_o,

    // Winner towards the channel mux
    output logic                                 req_o,
    output logic    [ADDR_WIDTH-1:0]             add_o,
    output mem_op_e                              wen_o,
    output logic    [DATA_WIDTH-1:0]             wdata_o,
    output logic    [DATA_WIDTH/8-1:0]           be_o,
    output logic    [ID_WIDTH-1:0]               id_o,
    input  logic                                 stall_i
);

    localparam int unsigned BE_WIDTH = DATA_WIDTH / 8;
    localparam int unsigned LOG_N    = $clog2(N_MASTER);

    // Stage l holds the inputs of tree level l, stage LOG_N is the root output
    logic    [LOG_N:0][N_MASTER-1:0]                 req_s;
    logic    [LOG_N:0][N_MASTER-1:0][ADDR_WIDTH-1:0] add_s;
    mem_op_e [LOG_N:0][N_MASTER-1:0]                 wen_s;
    logic    [LOG_N:0][N_MASTER-1:0][DATA_WIDTH-1:0] wdata_s;
    logic    [LOG_N:0][N_MASTER-1:0][BE_WIDTH-1:0]   be_s;
    logic    [LOG_N:0][N_MASTER-1:0][ID_WIDTH-1:0]   id_s;
    logic    [LOG_N:0][N_MASTER-1:0]                 stall_s;

    logic    [LOG_N-1:0]                             cnt_q;

    ////////////////////////////////////////////////////////////////////////////
    // Round-robin counter
    ////////////////////////////////////////////////////////////////////////////

    // Moves only on an accepted root request, wraps at N_MASTER
    always_ff @(posedge clk)
    begin
        if (!rst_n_i)
            cnt_q <= '0;
        else if (req_o && !stall_i)
            cnt_q <= cnt_q + 1'b1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Tree levels
    ////////////////////////////////////////////////////////////////////////////

    assign req_s[0]   = req_i;
    assign add_s[0]   = add_i;
    assign wen_s[0]   = wen_i;
    assign wdata_s[0] = wdata_i;
    assign be_s[0]    = be_i;
    assign id_s[0]    = id_i;
    assign stall_o    = stall_s[0];

    for (genvar l = 0; l < LOG_N; l++)
    begin : g_level
        for (genvar k = 0; k < (N_MASTER >> (l + 1)); k++)
        begin : g_node
            logic req_lo;
            logic req_hi;
            logic sel_hi;

            assign req_lo = req_s[l][2*k];
            assign req_hi = req_s[l][2*k+1];

            // Counter bit breaks the tie, otherwise the lone requester goes through
            assign sel_hi = (req_lo && req_hi) ? cnt_q[l] : req_hi;

            assign req_s[l+1][k]   = req_lo | req_hi;
            assign add_s[l+1][k]   = sel_hi ? add_s[l][2*k+1]   : add_s[l][2*k];
            assign wen_s[l+1][k]   = sel_hi ? wen_s[l][2*k+1]   : wen_s[l][2*k];
            assign wdata_s[l+1][k] = sel_hi ? wdata_s[l][2*k+1] : wdata_s[l][2*k];
            assign be_s[l+1][k]    = sel_hi ? be_s[l][2*k+1]    : be_s[l][2*k];
            assign id_s[l+1][k]    = sel_hi ? id_s[l][2*k+1]    : id_s[l][2*k];

            // Loser is stalled, winner inherits the stall from above
            assign stall_s[l][2*k]   = req_lo & (sel_hi | stall_s[l+1][k]);
            assign stall_s[l][2*k+1] = req_hi & (~sel_hi | stall_s[l+1][k]);
        end
    end

    // Entries above the node count of each stage carry nothing
    for (genvar l = 1; l <= LOG_N; l++)
    begin : g_unused
        for (genvar k = (N_MASTER >> l); k < N_MASTER; k++)
        begin : g_tie
            assign req_s[l][k]   = 1'b0;
            assign add_s[l][k]   = '0;
            assign wen_s[l][k]   = OP_WRITE;
            assign wdata_s[l][k] = '0;
            assign be_s[l][k]    = '0;
            assign id_s[l][k]    = '0;
            assign stall_s[l][k] = 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Root
    ////////////////////////////////////////////////////////////////////////////

    assign stall_s[LOG_N][0] = stall_i;

    assign req_o   = req_s[LOG_N][0];
    assign add_o   = add_s[LOG_N][0];
    assign wen_o   = wen_s[LOG_N][0];
    assign wdata_o = wdata_s[LOG_N][0];
    assign be_o    = be_s[LOG_N][0];
    assign id_o    = id_s[LOG_N][0];

endmodule : rr_arb_tree

//--- design/tcdm_req_pkg.sv
// Request-side definitions shared by the interconnect blocks and the testbench
package tcdm_req_pkg;

    // Default widths of the memory port
    localparam int unsigned DEF_ADDR_WIDTH = 32;
    localparam int unsigned DEF_DATA_WIDTH = 32;

    // Write enable as carried on the bus, active low write
    typedef enum logic
    {
        OP_WRITE = 1'b0,
        OP_READ  = 1'b1
    } mem_op_e;

endpackage : tcdm_req_pkg

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and judges the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert -Wno-fatal --top-module tb_top \
    --Mdir "$BUILD_DIR" -o tb_top_sim -f sim.f
if [ $? -ne 0 ]; then
    echo "Verilator build did not succeed"
    exit 1
fi

"./$BUILD_DIR/tb_top_sim" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Checks failed" "$LOG"; then
    echo "Simulation result: FAIL"
    exit 1
fi

echo "Simulation result: PASS"
exit 0

//--- sim.f
design/tcdm_req_pkg.sv
design/arb_pkg.sv
design/rr_arb_tree.sv
design/chan_mux2.sv
design/request_block_2ch.sv
verif/request_block_assertions.sv
verif/tb_checker.sv
verif/tb_top.sv

//--- verif/request_block_assertions.sv
`timescale 1ns/10ps

module request_block_assertions
    import arb_pkg::*;
#(
    parameter int unsigned  N_CH0    = 4,
    parameter int unsigned  N_CH1    = 2,
    localparam int unsigned ID_WIDTH = N_CH0 + N_CH1
)
(
    input logic                clk,
    input logic                rst_n_i,
    input logic [N_CH0-1:0]    req_ch0_i,
    input logic [N_CH1-1:0]    req_ch1_i,
    input logic [N_CH0-1:0]    stall_ch0_o,
    input logic [N_CH1-1:0]    stall_ch1_o,
    input logic                req_o,
    input logic [ID_WIDTH-1:0] id_o,
    input logic                stall_i,
    input logic [N_CH0-1:0]    r_valid_ch0_o,
    input logic [N_CH1-1:0]    r_valid_ch1_o
);

    int unsigned fail_cnt = 0;
    chan_sel_e   sel_model;

    // Shadow of the mux flag
    always_ff @(posedge clk)
    begin
        if (!rst_n_i)
            sel_model <= SEL_CH0;
        else if (req_o && !stall_i)
            sel_model <= (sel_model == SEL_CH0) ? SEL_CH1 : SEL_CH0;
    end

    idle_no_stall: assert property (@(posedge clk) disable iff (!rst_n_i)
        ((stall_ch0_o & ~req_ch0_i) == '0) && ((stall_ch1_o & ~req_ch1_i) == '0))
    else
    begin
        $error("stall seen by a master that does not request");
        fail_cnt++;
    end

    req_is_or: assert property (@(posedge clk) disable iff (!rst_n_i)
        req_o == ((|req_ch0_i) || (|req_ch1_i)))
    else
    begin
        $error("req_o differs from the OR of all requests");
        fail_cnt++;
    end

    rvalid_onehot: assert property (@(posedge clk) disable iff (!rst_n_i)
        $onehot0({r_valid_ch1_o, r_valid_ch0_o}))
    else
    begin
        $error("more than one response valid at once");
        fail_cnt++;
    end

    // On a conflict the memory ID comes from the flagged channel
    flag_picks: assert property (@(posedge clk) disable iff (!rst_n_i)
        ((|req_ch0_i) && (|req_ch1_i)) |-> ((sel_model == SEL_CH1) == (|id_o[ID_WIDTH-1:N_CH0])))
    else
    begin
        $error("channel conflict not resolved by the mux flag");
        fail_cnt++;
    end

endmodule : request_block_assertions

//--- verif/tb_checker.sv
`timescale 1ns/10ps

module tb_checker
    import tcdm_req_pkg::*, arb_pkg::*;
#(
    parameter int unsigned  N_CH0      = 4,
    parameter int unsigned  N_CH1      = 2,
    parameter int unsigned  ADDR_WIDTH = DEF_ADDR_WIDTH,
    parameter int unsigned  DATA_WIDTH = DEF_DATA_WIDTH,
    localparam int unsigned ID_WIDTH   = N_CH0 + N_CH1,
    localparam int unsigned BE_WIDTH   = DATA_WIDTH / 8
)
(
    input logic                                clk,
    input logic                                rst_n_i,
    input logic    [N_CH0-1:0]                 req_ch0_i,
    input logic    [N_CH0-1:0][ADDR_WIDTH-1:0] add_ch0_i,
    input mem_op_e [N_CH0-1:0]                 wen_ch0_i,
    input logic    [N_CH0-1:0][DATA_WIDTH-1:0] wdata_ch0_i,
    input logic    [N_CH0-1:0][BE_WIDTH-1:0]   be_ch0_i,
    input logic    [N_CH0-1:0][ID_WIDTH-1:0]   id_ch0_i,
    input logic    [N_CH0-1:0]                 stall_ch0_o,
    input logic    [N_CH1-1:0]                 req_ch1_i,
    input logic    [N_CH1-1:0][ADDR_WIDTH-1:0] add_ch1_i,
    input mem_op_e [N_CH1-1:0]                 wen_ch1_i,
    input logic    [N_CH1-1:0][DATA_WIDTH-1:0] wdata_ch1_i,
    input logic    [N_CH1-1:0][BE_WIDTH-1:0]   be_ch1_i,
    input logic    [N_CH1-1:0][ID_WIDTH-1:0]   id_ch1_i,
    input logic    [N_CH1-1:0]                 stall_ch1_o,
    input logic                                req_o,
    input logic    [ADDR_WIDTH-1:0]            add_o,
    input mem_op_e                             wen_o,
    input logic    [DATA_WIDTH-1:0]            wdata_o,
    input logic    [BE_WIDTH-1:0]              be_o,
    input logic    [ID_WIDTH-1:0]              id_o,
    input logic                                stall_i,
    input logic                                r_valid_i,
    input logic    [ID_WIDTH-1:0]              r_id_i,
    input logic    [N_CH0-1:0]                 r_valid_ch0_o,
    input logic    [N_CH1-1:0]                 r_valid_ch1_o
);

    typedef struct packed {
        logic                  req;
        logic [ADDR_WIDTH-1:0] add;
        logic                  wen;
        logic [DATA_WIDTH-1:0] wdata;
        logic [BE_WIDTH-1:0]   be;
        logic [ID_WIDTH-1:0]   id;
        logic [N_CH0-1:0]      stall0;
        logic [N_CH1-1:0]      stall1;
        logic [N_CH0-1:0]      rv0;
        logic [N_CH1-1:0]      rv1;
        logic                  acc0;
        logic                  acc1;
        logic                  acc_mem;
    } expect_t;

    // Model state, next values are worked out mid-cycle and taken at the edge
    int unsigned cnt0      = 0;
    int unsigned cnt1      = 0;
    chan_sel_e   flag      = SEL_CH0;
    int unsigned cnt0_nxt  = 0;
    int unsigned cnt1_nxt  = 0;
    chan_sel_e   flag_nxt  = SEL_CH0;
    expect_t     exp_q;

    string       test_name    = "reset";
    int unsigned test_errors  = 0;
    int unsigned total_errors = 0;
    int unsigned tests_run    = 0;
    int unsigned tests_failed = 0;

    // Winner of a tree of n masters, -1 when nobody requests
    function automatic int tree_pick(input logic [31:0] req, input int n, input int cnt);
        int cand [32];
        int width;
        int lo;
        int hi;
        for (int k = 0; k < 32; k++)
            cand[k] = (k < n && req[k]) ? k : -1;
        width = n;
        for (int l = 0; width > 1; l++)
        begin
            for (int k = 0; k < width / 2; k++)
            begin
                lo = cand[2*k];
                hi = cand[2*k+1];
                if (lo >= 0 && hi >= 0)
                    cand[k] = cnt[l] ? hi : lo;
                else
                    cand[k] = (hi >= 0) ? hi : lo;
            end
            width = width / 2;
        end
        return cand[0];
    endfunction

    function automatic expect_t predict_outputs();
        expect_t e;
        int      w0;
        int      w1;
        logic    pick1;
        logic    cst0;
        logic    cst1;
        e  = '0;
        w0 = tree_pick(32'(req_ch0_i), N_CH0, cnt0);
        w1 = tree_pick(32'(req_ch1_i), N_CH1, cnt1);
        pick1 = (w0 >= 0 && w1 >= 0) ? (flag == SEL_CH1) : (w1 >= 0);
        e.req = (w0 >= 0) || (w1 >= 0);
        if (pick1)
        begin
            e.add   = add_ch1_i[w1];
            e.wen   = wen_ch1_i[w1];
            e.wdata = wdata_ch1_i[w1];
            e.be    = be_ch1_i[w1];
            e.id    = id_ch1_i[w1];
        end
        else if (w0 >= 0)
        begin
            e.add   = add_ch0_i[w0];
            e.wen   = wen_ch0_i[w0];
            e.wdata = wdata_ch0_i[w0];
            e.be    = be_ch0_i[w0];
            e.id    = id_ch0_i[w0];
        end
        // Channel loses the mux, or wins it while memory stalls
        cst0 = (w0 >= 0) && (pick1 || stall_i);
        cst1 = (w1 >= 0) && (!pick1 || stall_i);
        for (int i = 0; i < N_CH0; i++)
            e.stall0[i] = req_ch0_i[i] && (i != w0 || cst0);
        for (int j = 0; j < N_CH1; j++)
            e.stall1[j] = req_ch1_i[j] && (j != w1 || cst1);
        e.rv0     = r_valid_i ? r_id_i[N_CH0-1:0] : '0;
        e.rv1     = r_valid_i ? r_id_i[ID_WIDTH-1:N_CH0] : '0;
        e.acc0    = (w0 >= 0) && !cst0;
        e.acc1    = (w1 >= 0) && !cst1;
        e.acc_mem = e.req && !stall_i;
        return e;
    endfunction

    task automatic check_field(input string field, input logic [63:0] expv,
                               input logic [63:0] actv);
        if (actv !== expv)
        begin
            $display("[FAIL] %s: %s expected %h, actual %h", test_name, field, expv, actv);
            test_errors++;
            total_errors++;
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        tests_run++;
        if (test_errors == 0)
            $display("Test %-14s ok", test_name);
        else
        begin
            tests_failed++;
            $display("Test %-14s %0d mismatches", test_name, test_errors);
        end
    endtask

    task automatic report_totals(input int unsigned assert_fails);
        $display("Tests run: %0d, tests with mismatches: %0d, mismatches: %0d, %s %0d",
                 tests_run, tests_failed, total_errors, "assertion failures:", assert_fails);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Comparison mid-cycle, inputs settled since the last edge
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clk)
    begin
        if (rst_n_i !== 1'b1)
        begin
            cnt0_nxt = 0;
            cnt1_nxt = 0;
            flag_nxt = SEL_CH0;
        end
        else
        begin
            exp_q = predict_outputs();
            check_field("req_o", 64'(exp_q.req), 64'(req_o));
            if (exp_q.req)
            begin
                check_field("add_o", 64'(exp_q.add), 64'(add_o));
                check_field("wen_o", 64'(exp_q.wen), 64'(wen_o));
                check_field("wdata_o", 64'(exp_q.wdata), 64'(wdata_o));
                check_field("be_o", 64'(exp_q.be), 64'(be_o));
                check_field("id_o", 64'(exp_q.id), 64'(id_o));
            end
            check_field("stall_ch0_o", 64'(exp_q.stall0), 64'(stall_ch0_o));
            check_field("stall_ch1_o", 64'(exp_q.stall1), 64'(stall_ch1_o));
            check_field("r_valid_ch0_o", 64'(exp_q.rv0), 64'(r_valid_ch0_o));
            check_field("r_valid_ch1_o", 64'(exp_q.rv1), 64'(r_valid_ch1_o));
            cnt0_nxt = exp_q.acc0 ? (cnt0 + 1) % N_CH0 : cnt0;
            cnt1_nxt = exp_q.acc1 ? (cnt1 + 1) % N_CH1 : cnt1;
            if (exp_q.acc_mem)
                flag_nxt = (flag == SEL_CH0) ? SEL_CH1 : SEL_CH0;
            else
                flag_nxt = flag;
        end
    end

    always @(posedge clk)
    begin
        cnt0 <= cnt0_nxt;
        cnt1 <= cnt1_nxt;
        flag <= flag_nxt;
    end

endmodule : tb_checker

//--- verif/tb_top.sv
`timescale 1ns/10ps

module tb_top
    import tcdm_req_pkg::*;
();

    localparam int unsigned N_CH0        = 4;
    localparam int unsigned N_CH1        = 2;
    localparam int unsigned ID_WIDTH     = N_CH0 + N_CH1;
    localparam int unsigned BE_WIDTH     = DEF_DATA_WIDTH / 8;
    localparam int unsigned CLK_PERIOD   = 40;
    localparam int unsigned RESET_CYCLES = 10;
    localparam int unsigned RAND_CYCLES  = 300;
    // Reset, single, tree, both, stall, response and random tests plus slack
    localparam int unsigned TOTAL_CYCLES = RESET_CYCLES + 2 * ID_WIDTH + 16 + 16 + 18
                                           + ID_WIDTH + 1 + RAND_CYCLES + 8;

    logic                                    clk;
    logic                                    rst_n_i;
    logic    [N_CH0-1:0]                     req_ch0_i;
    logic    [N_CH0-1:0][DEF_ADDR_WIDTH-1:0] add_ch0_i;
    mem_op_e [N_CH0-1:0]                     wen_ch0_i;
    logic    [N_CH0-1:0][DEF_DATA_WIDTH-1:0] wdata_ch0_i;
    logic    [N_CH0-1:0][BE_WIDTH-1:0]       be_ch0_i;
    logic    [N_CH0-1:0][ID_WIDTH-1:0]       id_ch0_i;
    logic    [N_CH0-1:0]                     stall_ch0_o;
    logic    [N_CH1-1:0]                     req_ch1_i;
    logic    [N_CH1-1:0][DEF_ADDR_WIDTH-1:0] add_ch1_i;
    mem_op_e [N_CH1-1:0]                     wen_ch1_i;
    logic    [N_CH1-1:0][DEF_DATA_WIDTH-1:0] wdata_ch1_i;
    logic    [N_CH1-1:0][BE_WIDTH-1:0]       be_ch1_i;
    logic    [N_CH1-1:0][ID_WIDTH-1:0]       id_ch1_i;
    logic    [N_CH1-1:0]                     stall_ch1_o;
    logic                                    req_o;
    logic    [DEF_ADDR_WIDTH-1:0]            add_o;
    mem_op_e                                 wen_o;
    logic    [DEF_DATA_WIDTH-1:0]            wdata_o;
    logic    [BE_WIDTH-1:0]                  be_o;
    logic    [ID_WIDTH-1:0]                  id_o;
    logic                                    stall_i;
    logic                                    r_valid_i;
    logic    [ID_WIDTH-1:0]                  r_id_i;
    logic    [N_CH0-1:0]                     r_valid_ch0_o;
    logic    [N_CH1-1:0]                     r_valid_ch1_o;

    integer                                  seed;
    logic    [ID_WIDTH-1:0]                  held;
    int unsigned                             assert_fails;

    request_block_2ch #(.N_CH0(N_CH0), .N_CH1(N_CH1)) UUT (.*);

    tb_checker #(.N_CH0(N_CH0), .N_CH1(N_CH1)) u_checker (.*);

    bind request_block_2ch request_block_assertions
    #(
        .N_CH0 ( N_CH0 ),
        .N_CH1 ( N_CH1 )
    )
    u_assertions
    (
        .clk           ( clk           ),
        .rst_n_i       ( rst_n_i       ),
        .req_ch0_i     ( req_ch0_i     ),
        .req_ch1_i     ( req_ch1_i     ),
        .stall_ch0_o   ( stall_ch0_o   ),
        .stall_ch1_o   ( stall_ch1_o   ),
        .req_o         ( req_o         ),
        .id_o          ( id_o          ),
        .stall_i       ( stall_i       ),
        .r_valid_ch0_o ( r_valid_ch0_o ),
        .r_valid_ch1_o ( r_valid_ch1_o )
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial
    begin
        #(2 * TOTAL_CYCLES * CLK_PERIOD);
        $display("Timeout: tests did not finish within %0d cycles", 2 * TOTAL_CYCLES);
        $display("Checks failed");
        $finish;
    end

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic clear_inputs();
        req_ch0_i = '0;
        req_ch1_i = '0;
        stall_i   = 1'b0;
        r_valid_i = 1'b0;
        r_id_i    = '0;
    endtask

    // Master index m runs over channel 0 first, then channel 1
    task automatic set_req(input int m, input logic on);
        if (m < N_CH0)
            req_ch0_i[m] = on;
        else
            req_ch1_i[m - N_CH0] = on;
    endtask

    task automatic randomize_master(input int m);
        if (m < N_CH0)
        begin
            add_ch0_i[m]   = $random(seed);
            wen_ch0_i[m]   = (($random(seed) & 1) != 0) ? OP_READ : OP_WRITE;
            wdata_ch0_i[m] = $random(seed);
            be_ch0_i[m]    = BE_WIDTH'($random(seed));
        end
        else
        begin
            add_ch1_i[m - N_CH0]   = $random(seed);
            wen_ch1_i[m - N_CH0]   = (($random(seed) & 1) != 0) ? OP_READ : OP_WRITE;
            wdata_ch1_i[m - N_CH0] = $random(seed);
            be_ch1_i[m - N_CH0]    = BE_WIDTH'($random(seed));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        seed    = 32'h7d39;
        rst_n_i = 1'b0;
        clear_inputs();
        for (int m = 0; m < ID_WIDTH; m++)
        begin
            randomize_master(m);
            if (m < N_CH0)
                id_ch0_i[m] = ID_WIDTH'(1) << m;
            else
                id_ch1_i[m - N_CH0] = ID_WIDTH'(1) << m;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_n_i = 1'b1;
        next_cycle();

        u_checker.start_test("single_master");
        for (int m = 0; m < ID_WIDTH; m++)
        begin
            randomize_master(m);
            set_req(m, 1'b1);
            next_cycle();
            clear_inputs();
            next_cycle();
        end
        u_checker.finish_test();

        u_checker.start_test("tree_order");
        req_ch0_i = '1;
        repeat (16) next_cycle();
        u_checker.finish_test();

        u_checker.start_test("channel_alt");
        req_ch1_i = '1;
        repeat (16) next_cycle();
        u_checker.finish_test();

        // Order must pick up again after the back-pressure window
        u_checker.start_test("backpressure");
        req_ch1_i = '0;
        repeat (4) next_cycle();
        stall_i = 1'b1;
        repeat (6) next_cycle();
        stall_i = 1'b0;
        repeat (8) next_cycle();
        u_checker.finish_test();

        u_checker.start_test("resp_routing");
        clear_inputs();
        for (int b = 0; b < ID_WIDTH; b++)
        begin
            r_valid_i = 1'b1;
            r_id_i    = ID_WIDTH'(1) << b;
            next_cycle();
        end
        r_valid_i = 1'b0;
        r_id_i    = '1;
        next_cycle();
        u_checker.finish_test();

        // Stalled requests are held, the others are redrawn
        u_checker.start_test("random");
        for (int c = 0; c < RAND_CYCLES; c++)
        begin
            @(negedge clk);
            held = {req_ch1_i & stall_ch1_o, req_ch0_i & stall_ch0_o};
            next_cycle();
            for (int m = 0; m < ID_WIDTH; m++)
            begin
                if (!held[m])
                begin
                    randomize_master(m);
                    set_req(m, ($random(seed) & 1) != 0);
                end
            end
            stall_i   = ($random(seed) & 3) == 0;
            r_valid_i = ($random(seed) & 1) != 0;
            r_id_i    = ID_WIDTH'(1) << (($random(seed) & 32'h7fff_ffff) % ID_WIDTH);
        end
        next_cycle();
        u_checker.finish_test();

        assert_fails = UUT.u_assertions.fail_cnt;
        u_checker.report_totals(assert_fails);
        if (u_checker.total_errors == 0 && assert_fails == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule : tb_top
